// File: Makefile
# Verilator build and run for the Frogger game core

VERILATOR ?= verilator
TOP       ?= froggerTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ns
DEFINES   ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(DEFINES) -j $(JOBS) -f $(FLIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '>>> PASS' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) $(DEFINES) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+rtl
rtl/froggerPkg.sv
rtl/moveTicker.sv
rtl/carLanes.sv
rtl/collisionDetect.sv
rtl/gameCtrl.sv
rtl/froggerCore.sv
verification/froggerTb.sv

// File: rtl/carLanes.sv
`timescale 1ns/1ns
`default_nettype none

`include "frogger_params.svh"

module carLanes
(
    input  wire                i_Clk,
    input  wire                i_arstN,
    input  wire                i_tick,
    output froggerPkg::tCarRow o_cars
);

    logic [9:0] carX  [8];
    logic [9:0] nextX [8];

    function automatic logic [10:0] laneSpeed(input int lane);
        case (lane)
            0:       return 11'(`LANE_SPEED_0);
            1:       return 11'(`LANE_SPEED_1);
            2:       return 11'(`LANE_SPEED_2);
            default: return 11'(`LANE_SPEED_3);
        endcase
    endfunction

    // next position of every car with the wrap back to the left edge
    always_comb
    begin
        logic [10:0] sum;
        for (int k = 0; k < 8; k++)
        begin
            sum = {1'b0, carX[k]} + laneSpeed(k % 4);   // one spare bit so the sum never wraps
            if (sum >= 11'(`SCREEN_W))
                nextX[k] = 10'(sum - 11'(`SCREEN_W));
            else
                nextX[k] = sum[9:0];
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            for (int k = 0; k < 8; k++)
                carX[k] <= 10'(k * (`SCREEN_W / 8));    // cars start evenly spread
        end
        else if (i_tick)
        begin
            for (int k = 0; k < 8; k++)
                carX[k] <= nextX[k];
        end
    end

    assign o_cars = '{
        car0: carX[0],
        car1: carX[1],
        car2: carX[2],
        car3: carX[3],
        car4: carX[4],
        car5: carX[5],
        car6: carX[6],
        car7: carX[7]
    };

endmodule

`default_nettype wire

// File: rtl/collisionDetect.sv
`timescale 1ns/1ns
`default_nettype none

`include "frogger_params.svh"

module collisionDetect
(
    input  wire                 i_Clk,
    input  wire                 i_arstN,
    input  wire froggerPkg::tFrogPos i_frog,
    input  wire froggerPkg::tCarRow  i_cars,
    output logic                o_hit
);

    logic [9:0] carX [8];
    logic [7:0] overlap;

    assign carX[0] = i_cars.car0;
    assign carX[1] = i_cars.car1;
    assign carX[2] = i_cars.car2;
    assign carX[3] = i_cars.car3;
    assign carX[4] = i_cars.car4;
    assign carX[5] = i_cars.car5;
    assign carX[6] = i_cars.car6;
    assign carX[7] = i_cars.car7;

    function automatic logic [8:0] laneY(input int lane);
        case (lane)
            0:       return 9'(`LANE_Y_0);
            1:       return 9'(`LANE_Y_1);
            2:       return 9'(`LANE_Y_2);
            default: return 9'(`LANE_Y_3);
        endcase
    endfunction

    // frog and car sit on the tile grid vertically, so equal y means the same row
    // horizontally the two sprites overlap when each left edge lies before the other's right edge
    always_comb
    begin
        for (int k = 0; k < 8; k++)
        begin
            overlap[k] = (i_frog.y == laneY(k % 4))
                && ({1'b0, i_frog.x} < ({1'b0, carX[k]} + 11'(`TILE_SIZE)))
                && ({1'b0, carX[k]} < ({1'b0, i_frog.x} + 11'(`TILE_SIZE)));
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
            o_hit <= 1'b0;
        else
            o_hit <= |overlap;  // one cycle behind the positions it was computed from
    end

endmodule

`default_nettype wire

// File: rtl/froggerCore.sv
`timescale 1ns/1ns
`default_nettype none

module froggerCore
(
    input  wire                      i_Clk,
    input  wire                      i_arstN,
    input  wire                      i_start,
    input  wire                      i_moveValid,
    input  wire froggerPkg::tMove    i_move,
    output froggerPkg::tFrogPos      o_frog,
    output froggerPkg::tCarRow       o_cars,
    output froggerPkg::tGameStatus   o_status,
    output logic                     o_collision
);

    logic moveTick;     // paces the cars and the recovery after a hit

    moveTicker moveTicker0
    (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .o_tick  (moveTick)
    );

    carLanes carLanes0
    (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .i_tick  (moveTick),
        .o_cars  (o_cars)
    );

    // hit comes back one cycle after the positions it was computed from
    collisionDetect collisionDetect0
    (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .i_frog  (o_frog),
        .i_cars  (o_cars),
        .o_hit   (o_collision)
    );

    gameCtrl gameCtrl0
    (
        .i_Clk       (i_Clk),
        .i_arstN     (i_arstN),
        .i_start     (i_start),
        .i_moveValid (i_moveValid),
        .i_move      (i_move),
        .i_hit       (o_collision),
        .i_tick      (moveTick),
        .o_frog      (o_frog),
        .o_status    (o_status)
    );

endmodule

`default_nettype wire

// File: rtl/froggerPkg.sv
`default_nettype none

package froggerPkg;

    typedef enum logic [1:0]
    {
        MOVE_UP,
        MOVE_DOWN,
        MOVE_LEFT,
        MOVE_RIGHT
    } tMove;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_PLAY,
        ST_HIT,     // waiting for the next tick after losing a life
        ST_OVER
    } tGameState;

    typedef struct packed
    {
        logic [9:0] x;  // top-left corner of the frog sprite
        logic [8:0] y;
    } tFrogPos;

    // car k drives on lane k mod 4, so only x travels with the car
    typedef struct packed
    {
        logic [9:0] car0;
        logic [9:0] car1;
        logic [9:0] car2;
        logic [9:0] car3;
        logic [9:0] car4;
        logic [9:0] car5;
        logic [9:0] car6;
        logic [9:0] car7;
    } tCarRow;

    typedef struct packed
    {
        tGameState  state;
        logic [1:0] lives;
        logic [7:0] score;
    } tGameStatus;

endpackage

`default_nettype wire

// File: rtl/frogger_params.svh
`ifndef FROGGER_PARAMS_SVH
`define FROGGER_PARAMS_SVH

// sprite side in pixels and the distance of one frog step
`define TILE_SIZE       32

`define SCREEN_W        640
`define SCREEN_H        480

// top edge of each car row, all on the tile grid
`define LANE_Y_0        96
`define LANE_Y_1        160
`define LANE_Y_2        224
`define LANE_Y_3        288

// bottom row of the screen holds no cars
`define FROG_START_X    320
`define FROG_START_Y    448

// pixels per move tick for each lane
`define LANE_SPEED_0    1
`define LANE_SPEED_1    2
`define LANE_SPEED_2    3
`define LANE_SPEED_3    4

`define TICK_CYCLES     16  // clock cycles between two move ticks

`define START_LIVES     3   // must fit in the 2-bit lives counter

`endif

// File: rtl/gameCtrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "frogger_params.svh"

module gameCtrl
(
    input  wire                      i_Clk,
    input  wire                      i_arstN,
    input  wire                      i_start,
    input  wire                      i_moveValid,
    input  wire froggerPkg::tMove    i_move,
    input  wire                      i_hit,
    input  wire                      i_tick,
    output froggerPkg::tFrogPos      o_frog,
    output froggerPkg::tGameStatus   o_status
);

    localparam froggerPkg::tFrogPos StartPos = '{
        x: 10'(`FROG_START_X),
        y: 9'(`FROG_START_Y)
    };

    froggerPkg::tGameState stateQ;
    froggerPkg::tFrogPos   frogQ;
    logic [1:0]            livesQ;
    logic [7:0]            scoreQ;

    froggerPkg::tFrogPos   stepPos;
    logic                  stepOk;

    // candidate position one tile away and whether the whole sprite stays on screen
    always_comb
    begin
        stepPos = frogQ;
        stepOk  = 1'b0;
        case (i_move)
            froggerPkg::MOVE_UP:
            begin
                stepOk    = frogQ.y >= 9'(`TILE_SIZE);
                stepPos.y = 9'(frogQ.y - `TILE_SIZE);
            end
            froggerPkg::MOVE_DOWN:
            begin
                stepOk    = (10'(frogQ.y) + 10'(2 * `TILE_SIZE)) <= 10'(`SCREEN_H);
                stepPos.y = 9'(frogQ.y + `TILE_SIZE);
            end
            froggerPkg::MOVE_LEFT:
            begin
                stepOk    = frogQ.x >= 10'(`TILE_SIZE);
                stepPos.x = 10'(frogQ.x - `TILE_SIZE);
            end
            froggerPkg::MOVE_RIGHT:
            begin
                stepOk    = (11'(frogQ.x) + 11'(2 * `TILE_SIZE)) <= 11'(`SCREEN_W);
                stepPos.x = 10'(frogQ.x + `TILE_SIZE);
            end
            default:
            begin
                stepOk = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            stateQ <= froggerPkg::ST_IDLE;
            frogQ  <= StartPos;
            livesQ <= 2'(`START_LIVES);
            scoreQ <= '0;
        end
        else
        begin
            case (stateQ)
                froggerPkg::ST_IDLE:
                begin
                    if (i_start)
                        stateQ <= froggerPkg::ST_PLAY;
                end
                froggerPkg::ST_PLAY:
                begin
                    if (i_hit)  // a hit wins over a move in the same cycle
                    begin
                        livesQ <= livesQ - 2'd1;
                        frogQ  <= StartPos;
                        stateQ <= froggerPkg::ST_HIT;
                    end
                    else if (i_moveValid && stepOk)
                    begin
                        if (stepPos.y == '0)    // the frog crossed the road and starts again
                        begin
                            scoreQ <= scoreQ + 8'd1;
                            frogQ  <= StartPos;
                        end
                        else
                        begin
                            frogQ <= stepPos;
                        end
                    end
                end
                froggerPkg::ST_HIT:
                begin
                    // the tick gives the player a short pause before play resumes
                    if (i_tick)
                        stateQ <= (livesQ != 2'd0) ? froggerPkg::ST_PLAY : froggerPkg::ST_OVER;
                end
                froggerPkg::ST_OVER:
                begin
                    if (i_start)
                    begin
                        livesQ <= 2'(`START_LIVES);
                        scoreQ <= '0;
                        stateQ <= froggerPkg::ST_PLAY;
                    end
                end
                default:
                begin
                    stateQ <= froggerPkg::ST_IDLE;
                end
            endcase
        end
    end

    assign o_frog   = frogQ;
    assign o_status = '{state: stateQ, lives: livesQ, score: scoreQ};

endmodule

`default_nettype wire

// File: rtl/moveTicker.sv
`timescale 1ns/1ns
`default_nettype none

`include "frogger_params.svh"

module moveTicker
(
    input  wire  i_Clk,
    input  wire  i_arstN,
    output logic o_tick
);

    // a one-cycle period still needs a one-bit counter
    localparam int CntW = (`TICK_CYCLES > 1) ? $clog2(`TICK_CYCLES) : 1;
    localparam logic [CntW-1:0] CntLast = CntW'(`TICK_CYCLES - 1);

    logic [CntW-1:0] cntQ;

    // the tick is registered, so it rises in the cycle after the counter wraps
    always_ff @(posedge i_Clk or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            cntQ   <= '0;
            o_tick <= 1'b0;
        end
        else if (cntQ == CntLast)
        begin
            cntQ   <= '0;
            o_tick <= 1'b1;     // first pulse lands TICK_CYCLES cycles after reset
        end
        else
        begin
            cntQ   <= cntQ + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verification/froggerTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "frogger_params.svh"

module froggerTb;

    localparam int ClkPeriod   = 10;
    localparam int ResetCycles = 10;
    localparam int NumCycles   = 8000;
    localparam int PhaseLen    = 400;   // stimulus alternates between free and up-biased phases
    localparam int WatchdogNs  = (ResetCycles + NumCycles + 200) * ClkPeriod;

    logic                   i_Clk;
    logic                   i_arstN;
    logic                   i_start;
    logic                   i_moveValid;
    froggerPkg::tMove       i_move;
    froggerPkg::tFrogPos    o_frog;
    froggerPkg::tCarRow     o_cars;
    froggerPkg::tGameStatus o_status;
    logic                   o_collision;

    // reference model state with one register per DUT register
    int                    mCnt;
    bit                    mTick;
    int                    mCars [8];
    bit                    mHit;
    froggerPkg::tGameState mState;
    int                    mFrogX;
    int                    mFrogY;
    int                    mLives;
    int                    mScore;

    logic [31:0] rngState;
    int          errCount;
    int          checkCount;
    int          hitCount;
    int          scoreCount;
    int          overCount;

    froggerCore dut0
    (
        .i_Clk       (i_Clk),
        .i_arstN     (i_arstN),
        .i_start     (i_start),
        .i_moveValid (i_moveValid),
        .i_move      (i_move),
        .o_frog      (o_frog),
        .o_cars      (o_cars),
        .o_status    (o_status),
        .o_collision (o_collision)
    );

    initial i_Clk = 1'b0;
    always #(ClkPeriod / 2) i_Clk = ~i_Clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int laneSpeed(input int lane);
        case (lane)
            0:       return `LANE_SPEED_0;
            1:       return `LANE_SPEED_1;
            2:       return `LANE_SPEED_2;
            default: return `LANE_SPEED_3;
        endcase
    endfunction

    function automatic int laneRowY(input int lane);
        case (lane)
            0:       return `LANE_Y_0;
            1:       return `LANE_Y_1;
            2:       return `LANE_Y_2;
            default: return `LANE_Y_3;
        endcase
    endfunction

    task automatic resetModel();
        mCnt  = 0;
        mTick = 1'b0;
        for (int k = 0; k < 8; k++)
            mCars[k] = 80 * k;
        mHit   = 1'b0;
        mState = froggerPkg::ST_IDLE;
        mFrogX = `FROG_START_X;
        mFrogY = `FROG_START_Y;
        mLives = `START_LIVES;
        mScore = 0;
    endtask

    // advance the model by one rising edge with every next value taken from the current ones
    task automatic stepModel();
        int                    nCnt;
        bit                    nTick;
        int                    nCars [8];
        bit                    nHit;
        froggerPkg::tGameState nState;
        int                    nFrogX;
        int                    nFrogY;
        int                    nLives;
        int                    nScore;
        int                    tx;
        int                    ty;
        nCnt   = (mCnt == `TICK_CYCLES - 1) ? 0 : mCnt + 1;
        nTick  = (mCnt == `TICK_CYCLES - 1);
        nHit   = 1'b0;
        nState = mState;
        nFrogX = mFrogX;
        nFrogY = mFrogY;
        nLives = mLives;
        nScore = mScore;
        for (int k = 0; k < 8; k++)
        begin
            nCars[k] = mCars[k];
            if (mTick)
            begin
                nCars[k] = mCars[k] + laneSpeed(k % 4);
                if (nCars[k] >= `SCREEN_W)
                    nCars[k] = nCars[k] - `SCREEN_W;    // wrap back to the left edge
            end
            if (mFrogY == laneRowY(k % 4) && mFrogX < mCars[k] + `TILE_SIZE
                && mCars[k] < mFrogX + `TILE_SIZE)
                nHit = 1'b1;
        end
        case (mState)
            froggerPkg::ST_IDLE:
            begin
                if (i_start)
                    nState = froggerPkg::ST_PLAY;
            end
            froggerPkg::ST_PLAY:
            begin
                if (mHit)
                begin
                    nLives = mLives - 1;
                    nFrogX = `FROG_START_X;
                    nFrogY = `FROG_START_Y;
                    nState = froggerPkg::ST_HIT;
                    hitCount++;
                end
                else if (i_moveValid)
                begin
                    tx = mFrogX;
                    ty = mFrogY;
                    case (i_move)
                        froggerPkg::MOVE_UP:    ty = mFrogY - `TILE_SIZE;
                        froggerPkg::MOVE_DOWN:  ty = mFrogY + `TILE_SIZE;
                        froggerPkg::MOVE_LEFT:  tx = mFrogX - `TILE_SIZE;
                        default:                tx = mFrogX + `TILE_SIZE;
                    endcase
                    // only steps that keep the whole sprite on screen count
                    if (tx >= 0 && tx + `TILE_SIZE <= `SCREEN_W
                        && ty >= 0 && ty + `TILE_SIZE <= `SCREEN_H)
                    begin
                        if (ty == 0)
                        begin
                            nScore = (mScore + 1) % 256;
                            nFrogX = `FROG_START_X;
                            nFrogY = `FROG_START_Y;
                            scoreCount++;
                        end
                        else
                        begin
                            nFrogX = tx;
                            nFrogY = ty;
                        end
                    end
                end
            end
            froggerPkg::ST_HIT:
            begin
                if (mTick)
                begin
                    nState = (mLives > 0) ? froggerPkg::ST_PLAY : froggerPkg::ST_OVER;
                    if (mLives == 0)
                        overCount++;
                end
            end
            default:
            begin
                if (i_start)
                begin
                    nLives = `START_LIVES;
                    nScore = 0;
                    nState = froggerPkg::ST_PLAY;
                end
            end
        endcase
        mCnt   = nCnt;
        mTick  = nTick;
        mCars  = nCars;
        mHit   = nHit;
        mState = nState;
        mFrogX = nFrogX;
        mFrogY = nFrogY;
        mLives = nLives;
        mScore = nScore;
    endtask

    task automatic compareValue(input string name, input logic [79:0] got,
                                input logic [79:0] exp);
        checkCount++;
        if (got !== exp)
        begin
            errCount++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic checkOutputs();
        froggerPkg::tCarRow     expCars;
        froggerPkg::tFrogPos    expFrog;
        froggerPkg::tGameStatus expStatus;
        expCars.car0     = 10'(mCars[0]);
        expCars.car1     = 10'(mCars[1]);
        expCars.car2     = 10'(mCars[2]);
        expCars.car3     = 10'(mCars[3]);
        expCars.car4     = 10'(mCars[4]);
        expCars.car5     = 10'(mCars[5]);
        expCars.car6     = 10'(mCars[6]);
        expCars.car7     = 10'(mCars[7]);
        expFrog.x        = 10'(mFrogX);
        expFrog.y        = 9'(mFrogY);
        expStatus.state  = mState;
        expStatus.lives  = 2'(mLives);
        expStatus.score  = 8'(mScore);
        compareValue("o_cars", 80'(o_cars), 80'(expCars));
        compareValue("o_frog", 80'(o_frog), 80'(expFrog));
        compareValue("o_status", 80'(o_status), 80'(expStatus));
        compareValue("o_collision", 80'(o_collision), 80'(mHit));
    endtask

    // new inputs for the next rising edge are drawn from the xorshift stream
    task automatic driveInputs(input int cycle);
        logic [31:0] r;
        bit          upBias;
        rngState = xorshift32(rngState);
        r        = rngState;
        upBias   = ((cycle / PhaseLen) % 2) == 1;
        i_moveValid = (r[2:0] != 3'd0);
        if (upBias && r[5:4] != 2'd0)
            i_move = froggerPkg::MOVE_UP;
        else
            i_move = froggerPkg::tMove'(r[7:6]);
        if (mState == froggerPkg::ST_IDLE)
            i_start = 1'b1;
        else if (mState == froggerPkg::ST_OVER)
            i_start = (r[11:8] == 4'd0);    // linger a little so moves in ST_OVER get tried
        else
            i_start = (r[19:12] == 8'd0);   // stray starts during play must do nothing
    endtask

    initial
    begin
        #(WatchdogNs);
        $display("timeout: the run did not finish within %0d ns", WatchdogNs);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        rngState    = 32'h5ed1;
        errCount    = 0;
        checkCount  = 0;
        hitCount    = 0;
        scoreCount  = 0;
        overCount   = 0;
        i_arstN     = 1'b0;
        i_start     = 1'b0;
        i_moveValid = 1'b0;
        i_move      = froggerPkg::MOVE_UP;
        resetModel();
        repeat (ResetCycles) @(negedge i_Clk);
        checkOutputs();
        i_arstN = 1'b1;
        for (int c = 0; c < NumCycles; c++)
        begin
            @(posedge i_Clk);
            stepModel();
            @(negedge i_Clk);
            checkOutputs();
            driveInputs(c);
        end
        if (hitCount == 0)
        begin
            errCount++;
            $display("coverage: the frog was never hit by a car");
        end
        if (scoreCount == 0)
        begin
            errCount++;
            $display("coverage: the frog never reached the top row");
        end
        if (overCount == 0)
        begin
            errCount++;
            $display("coverage: no game ever ended");
        end
        $display("checks %0d, errors %0d, hits %0d, scores %0d, game overs %0d",
                 checkCount, errCount, hitCount, scoreCount, overCount);
        if (errCount == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
